/* vlog.f */
design/dcache_pkg.sv
design/dcache_tags.sv
design/dcache_data.sv
design/dcache_ctrl.sv
design/dcache_top.sv
dv/mem_model.sv
dv/dcache_tb.sv

/* Makefile */
.PHONY: run clean

obj_dir/Vdcache_tb: vlog.f $(shell cat vlog.f)
	verilator --binary --timing --top-module dcache_tb -f vlog.f

run: obj_dir/Vdcache_tb
	@out="$$(./obj_dir/Vdcache_tb)"; echo "$$out"; echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir

/* dv/dcache_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_tb;
  import dcache_pkg::*;

  localparam word_t FILL_XOR   = 32'h3C5A_96E1;
  localparam int    ACCESSES   = 60;
  localparam int    MAX_CYCLES = ACCESSES * (2 * WORDS_PER_LINE * 4 + 10);

  logic     clk;
  logic     rst;
  logic     req;
  logic     wreq;
  addr_t    addr;
  word_t    din;
  byte_en_t wbyte;
  logic     ok;
  logic     busy;
  word_t    rdata;
  logic     sen;
  addr_t    raddr;
  logic     rdata_ok;
  word_t    sdata;
  logic     wen;
  addr_t    waddr;
  word_t    wdata;
  logic     wdata_ok;

  word_t shadow [addr_t];
  word_t wb_words [$];   // Words seen on the last writeback
  addr_t wb_addr;
  addr_t rf_addr;
  int    refill_cnt;
  int    value_errs;
  int    other_errs;
  int    cycles = 0;
  int    seed;

  dcache_top UUT (.*);

  mem_model #(.FILL_XOR(FILL_XOR)) u_mem (.*);

  initial
  begin
    clk = 1'b0;
    forever
      #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    ctrl_state_t stuck;
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES)
    begin
      stuck = UUT.u_ctrl.state;
      $display("Timeout after %0d cycles, controller stuck in %s", cycles, stuck.name());
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Bus monitor
  always @(negedge clk)
  begin
    if (wen && wdata_ok)
    begin
      wb_words.push_back(wdata);
      wb_addr = waddr;
    end
    if (sen && rdata_ok)
    begin
      refill_cnt = refill_cnt + 1;
      rf_addr    = raddr;
    end
  end

  ////////////////////////////////////////
  // Shadow memory and checks
  ////////////////////////////////////////

  function automatic addr_t make_addr(tag_t t, set_t s, word_idx_t w);
    return {t, s, w, 2'b00};
  endfunction

  function automatic word_t shadow_read(addr_t a);
    return shadow.exists(a) ? shadow[a] : (a ^ FILL_XOR);
  endfunction

  task automatic shadow_write(addr_t a, word_t d, byte_en_t be);
    word_t w;
    w = shadow_read(a);
    for (int b = 0; b < 4; b++)
    begin
      if (be[b])
        w[8*b +: 8] = d[8*b +: 8];
    end
    shadow[a] = w;
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp)
    begin
      value_errs++;
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp)
    begin
      value_errs++;
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp)
    begin
      value_errs++;
      $display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_problem(string what);
    other_errs++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  task automatic expect_hit(int lat);
    if (lat != 1)
      report_problem($sformatf("hit answered after %0d cycles instead of 1", lat));
  endtask

  // One CPU access; reads are checked against the shadow
  task automatic access(logic w, addr_t a, word_t d, byte_en_t be, output int lat);
    word_t expected;
    expected = shadow_read(a);
    if (w)
      shadow_write(a, d, be);
    refill_cnt = 0;
    wb_words.delete();
    @(posedge clk);
    #1;
    check_bit("busy", busy, 1'b0);
    req   = 1'b1;
    wreq  = w;
    addr  = a;
    din   = d;
    wbyte = be;
    @(posedge clk);
    #1;
    req  = 1'b0;
    wreq = 1'b0;
    lat  = 0;
    do
    begin
      @(negedge clk);
      lat++;
    end
    while (ok !== 1'b1);
    check_bit("busy", busy, 1'b1);
    if (!w)
      check_word("rdata", rdata, expected);
  endtask

  task automatic check_writeback(addr_t base);
    if (wb_words.size() != WORDS_PER_LINE)
      report_problem($sformatf("writeback carried %0d words instead of 16", wb_words.size()));
    else
    begin
      check_addr("waddr", wb_addr, base);
      foreach (wb_words[i])
        check_word("wdata", wb_words[i], shadow_read(base + addr_t'(4 * i)));
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic reset_and_cold_read();
    int lat;
    check_bit("ok", ok, 1'b0);
    check_bit("busy", busy, 1'b0);
    check_bit("sen", sen, 1'b0);
    check_bit("wen", wen, 1'b0);
    access(1'b0, make_addr(22'd1, 4'd2, 4'd3), '0, '0, lat);
    if (refill_cnt != WORDS_PER_LINE)
      report_problem($sformatf("cold read refilled %0d words instead of 16", refill_cnt));
    check_addr("raddr", rf_addr, make_addr(22'd1, 4'd2, 4'd0));
    access(1'b0, make_addr(22'd1, 4'd2, 4'd9), '0, '0, lat);
    expect_hit(lat);
  endtask

  task automatic byte_writes();
    int lat;
    access(1'b1, make_addr(22'd1, 4'd2, 4'd4), 32'h1122_3344, 4'b0101, lat);
    expect_hit(lat);
    access(1'b1, make_addr(22'd1, 4'd2, 4'd4), 32'hAABB_CCDD, 4'b1000, lat);
    access(1'b0, make_addr(22'd1, 4'd2, 4'd4), '0, '0, lat);
    access(1'b1, make_addr(22'd3, 4'd2, 4'd0), 32'h5566_7788, 4'b0010, lat);  // Write miss
    access(1'b0, make_addr(22'd3, 4'd2, 4'd0), '0, '0, lat);
  endtask

  task automatic dirty_eviction();
    int lat;
    for (int t = 0; t < 4; t++)
      access(1'b1, make_addr(tag_t'(10 + t), 4'd5, word_idx_t'(t)), 32'hD00D_0000 + t,
             4'hF, lat);
    access(1'b1, make_addr(22'd14, 4'd5, 4'd7), 32'hFEED_BEEF, 4'b0011, lat);
    check_writeback(make_addr(22'd10, 4'd5, 4'd0));  // First filled is oldest
    access(1'b0, make_addr(22'd10, 4'd5, 4'd0), '0, '0, lat);
  endtask

  task automatic lru_order();
    int lat;
    for (int t = 0; t < 4; t++)
      access(1'b1, make_addr(tag_t'(20 + t), 4'd9, 4'd1), 32'hB0B0_0000 + t, 4'hF, lat);
    access(1'b0, make_addr(22'd20, 4'd9, 4'd2), '0, '0, lat);
    expect_hit(lat);
    access(1'b0, make_addr(22'd24, 4'd9, 4'd0), '0, '0, lat);
    check_writeback(make_addr(22'd21, 4'd9, 4'd0));
    access(1'b0, make_addr(22'd20, 4'd9, 4'd1), '0, '0, lat);
    expect_hit(lat);
  endtask

  task automatic random_traffic(int count);
    int          lat;
    logic [31:0] r;
    addr_t       a;
    for (int i = 0; i < count; i++)
    begin
      r = $random(seed);
      a = make_addr(tag_t'(40 + r[7:0] % 6), set_t'(12 + r[15:8] % 3), r[19:16]);
      access(r[20], a, $random(seed), r[24:21], lat);
    end
  endtask

  initial
  begin
    seed       = 76;
    value_errs = 0;
    other_errs = 0;
    refill_cnt = 0;
    rst        = 1'b1;
    req        = 1'b0;
    wreq       = 1'b0;
    addr       = '0;
    din        = '0;
    wbyte      = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    reset_and_cold_read();
    byte_writes();
    dirty_eviction();
    lru_order();
    random_traffic(40);
    $display("Done: %0d value errors, %0d other errors", value_errs, other_errs);
    if (value_errs + other_errs == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_model #(
  parameter dcache_pkg::word_t FILL_XOR = 32'h3C5A_96E1
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     sen,
  input  wire dcache_pkg::addr_t  raddr,
  output logic                    rdata_ok,
  output dcache_pkg::word_t       sdata,
  input  wire                     wen,
  input  wire dcache_pkg::addr_t  waddr,
  input  wire dcache_pkg::word_t  wdata,
  output logic                    wdata_ok
);
  import dcache_pkg::*;

  word_t     store [addr_t];  // Only words written back so far
  word_idx_t idx;
  int        gap;
  int        seed;

  function automatic word_t peek(addr_t a);
    return store.exists(a) ? store[a] : (a ^ FILL_XOR);
  endfunction

  initial
  begin
    seed     = 76;
    idx      = '0;
    gap      = 0;
    rdata_ok = 1'b0;
    wdata_ok = 1'b0;
    sdata    = '0;
    forever
    begin
      @(posedge clk);
      if (rdata_ok || wdata_ok)
        idx = idx + 1'b1;  // Strobe taken at this edge
      #1;
      rdata_ok = 1'b0;
      wdata_ok = 1'b0;
      if (rst || !(sen || wen))
        idx = '0;
      else if (gap > 0)
        gap = gap - 1;
      else
      begin
        if (sen)
        begin
          sdata    = peek({raddr[31:OFFSET_W], idx, 2'b00});
          rdata_ok = 1'b1;
        end
        else
        begin
          store[{waddr[31:OFFSET_W], idx, 2'b00}] = wdata;
          wdata_ok = 1'b1;
        end
        gap = $unsigned($random(seed)) % 4;  // Idle cycles before next strobe
      end
    end
  end

endmodule

`default_nettype wire

/* design/dcache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
  input  wire                          clk,
  input  wire                          rst,
  // CPU side
  input  wire                          req,
  input  wire                          wreq,
  input  wire dcache_pkg::addr_t       addr,
  input  wire dcache_pkg::word_t       din,
  input  wire dcache_pkg::byte_en_t    wbyte,
  output logic                         ok,
  output logic                         busy,
  output dcache_pkg::word_t            rdata,
  // Memory side
  output logic                         sen,
  output dcache_pkg::addr_t            raddr,
  input  wire                          rdata_ok,
  input  wire dcache_pkg::word_t       sdata,
  output logic                         wen,
  output dcache_pkg::addr_t            waddr,
  output dcache_pkg::word_t            wdata,
  input  wire                          wdata_ok
);
  import dcache_pkg::*;

  set_t      tag_set;
  tag_t      tag_tag;
  logic      hit;
  way_t      hit_way;
  way_t      victim_way;
  logic      victim_dirty;
  tag_t      victim_tag;
  logic      touch;
  logic      touch_dirty;
  way_t      touch_way;
  logic      fill;
  way_t      fill_way;
  way_t      data_way;
  word_idx_t data_word;
  byte_en_t  data_wbyte;
  word_t     data_wdata;
  word_t     data_rdata;

  dcache_tags u_tags (
    .clk          (clk),
    .rst          (rst),
    .set          (tag_set),
    .tag          (tag_tag),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .touch        (touch),
    .touch_dirty  (touch_dirty),
    .touch_way    (touch_way),
    .fill         (fill),
    .fill_way     (fill_way)
  );

  // Shares the set index with the tag store
  dcache_data u_data (
    .clk   (clk),
    .set   (tag_set),
    .way   (data_way),
    .word  (data_word),
    .wbyte (data_wbyte),
    .wdata (data_wdata),
    .rdata (data_rdata)
  );

  dcache_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .wreq         (wreq),
    .wbyte        (wbyte),
    .addr         (addr),
    .din          (din),
    .ok           (ok),
    .busy         (busy),
    .rdata        (rdata),
    .tag_set      (tag_set),
    .tag_tag      (tag_tag),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .touch        (touch),
    .touch_dirty  (touch_dirty),
    .touch_way    (touch_way),
    .fill         (fill),
    .fill_way     (fill_way),
    .data_way     (data_way),
    .data_word    (data_word),
    .data_wbyte   (data_wbyte),
    .data_wdata   (data_wdata),
    .data_rdata   (data_rdata),
    .sen          (sen),
    .raddr        (raddr),
    .rdata_ok     (rdata_ok),
    .sdata        (sdata),
    .wen          (wen),
    .waddr        (waddr),
    .wdata        (wdata),
    .wdata_ok     (wdata_ok)
  );

endmodule

`default_nettype wire

/* design/dcache_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          req,
  input  wire                          wreq,
  input  wire dcache_pkg::byte_en_t    wbyte,
  input  wire dcache_pkg::addr_t       addr,
  input  wire dcache_pkg::word_t       din,
  output logic                         ok,
  output logic                         busy,
  output dcache_pkg::word_t            rdata,
  // Tag store
  output dcache_pkg::set_t             tag_set,
  output dcache_pkg::tag_t             tag_tag,
  input  wire                          hit,
  input  wire dcache_pkg::way_t        hit_way,
  input  wire dcache_pkg::way_t        victim_way,
  input  wire                          victim_dirty,
  input  wire dcache_pkg::tag_t        victim_tag,
  output logic                         touch,
  output logic                         touch_dirty,
  output dcache_pkg::way_t             touch_way,
  output logic                         fill,
  output dcache_pkg::way_t             fill_way,
  // Data store
  output dcache_pkg::way_t             data_way,
  output dcache_pkg::word_idx_t        data_word,
  output dcache_pkg::byte_en_t         data_wbyte,
  output dcache_pkg::word_t            data_wdata,
  input  wire dcache_pkg::word_t       data_rdata,
  // Memory bus
  output logic                         sen,
  output dcache_pkg::addr_t            raddr,
  input  wire                          rdata_ok,
  input  wire dcache_pkg::word_t       sdata,
  output logic                         wen,
  output dcache_pkg::addr_t            waddr,
  output dcache_pkg::word_t            wdata,
  input  wire                          wdata_ok
);
  import dcache_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nx;
  word_idx_t   cnt;       // Burst word counter
  logic        last;
  way_t        acc_way;

  addr_t       addr_q;
  word_t       din_q;
  byte_en_t    wbyte_q;
  logic        wreq_q;
  way_t        vway;
  tag_t        vtag;

  assign last = (cnt == word_idx_t'(WORDS_PER_LINE - 1));

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  always_comb
  begin
    state_nx = state;
    case (state)
      IDLE:
        if (req)
          state_nx = LOOKUP;
      LOOKUP:
      begin
        if (hit)
          state_nx = IDLE;
        else if (victim_dirty)
          state_nx = WRITEBACK;
        else
          state_nx = REFILL;
      end
      WRITEBACK:
        if (wdata_ok && last)
          state_nx = REFILL;
      REFILL:
        if (rdata_ok && last)
          state_nx = RESPOND;
      RESPOND:
        state_nx = IDLE;
      default:
        state_nx = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state  <= IDLE;
      cnt    <= '0;
      wreq_q <= 1'b0;
    end
    else
    begin
      state <= state_nx;
      if (state == IDLE && req)
        wreq_q <= wreq;
      if (state == LOOKUP)
        cnt <= '0;
      else if ((state == WRITEBACK && wdata_ok) || (state == REFILL && rdata_ok))
        cnt <= cnt + 1'b1;  // Wraps to 0 between bursts
    end
  end

  // Request and victim capture
  always_ff @(posedge clk)
  begin
    if (state == IDLE && req)
    begin
      addr_q  <= addr;
      din_q   <= din;
      wbyte_q <= wbyte;
    end
    if (state == LOOKUP)
    begin
      vway <= victim_way;
      vtag <= victim_tag;
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign busy  = (state != IDLE);
  assign sen   = (state == REFILL);
  assign wen   = (state == WRITEBACK);
  assign ok    = (state == LOOKUP && hit) || (state == RESPOND);
  assign rdata = data_rdata;

  assign tag_set = addr_q[OFFSET_W +: SET_W];
  assign tag_tag = addr_q[OFFSET_W + SET_W +: TAG_W];
  assign raddr   = {tag_tag, tag_set, {OFFSET_W{1'b0}}};
  assign waddr   = {vtag, tag_set, {OFFSET_W{1'b0}}};
  assign wdata   = data_rdata;  // Victim word at cnt

  // Hit way on lookup, victim way for the rest
  assign acc_way = (state == LOOKUP) ? hit_way : vway;

  assign touch       = ok;
  assign touch_dirty = ok && wreq_q;
  assign touch_way   = acc_way;
  assign fill        = (state == REFILL) && rdata_ok && last;
  assign fill_way    = vway;

  assign data_way   = acc_way;
  assign data_word  = (state == WRITEBACK || state == REFILL) ? cnt
                    : addr_q[OFFSET_W - WORD_IDX_W +: WORD_IDX_W];
  assign data_wdata = (state == REFILL) ? sdata : din_q;

  always_comb
  begin
    data_wbyte = '0;
    if (state == REFILL && rdata_ok)
      data_wbyte = '1;  // Full word from refill
    else if (ok && wreq_q)
      data_wbyte = wbyte_q;
  end

  // Victim stays dirty and distinct from the missed line while it drains
  a_wb_dirty: assert property (@(posedge clk) disable iff (rst)
                               wen |-> victim_dirty && vtag != tag_tag);
  // Refilled line must be found in the victim way
  a_respond_hit: assert property (@(posedge clk) disable iff (rst)
                                  state == RESPOND |-> hit && hit_way == vway);

endmodule

`default_nettype wire

/* design/dcache_data.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_data (
  input  wire                          clk,
  input  wire dcache_pkg::set_t        set,
  input  wire dcache_pkg::way_t        way,
  input  wire dcache_pkg::word_idx_t   word,
  input  wire dcache_pkg::byte_en_t    wbyte,
  input  wire dcache_pkg::word_t       wdata,
  output dcache_pkg::word_t            rdata
);
  import dcache_pkg::*;

  localparam int LANES = $bits(byte_en_t);

  // Line storage, one word per way/set/index
  word_t mem [NUM_WAYS][NUM_SETS][WORDS_PER_LINE];

  always_ff @(posedge clk)
  begin
    for (int b = 0; b < LANES; b++)
    begin
      if (wbyte[b])
        mem[way][set][word][8*b +: 8] <= wdata[8*b +: 8];
    end
  end

  assign rdata = mem[way][set][word];  // Combinational read

endmodule

`default_nettype wire

/* design/dcache_tags.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_tags (
  input  wire                     clk,
  input  wire                     rst,
  input  wire dcache_pkg::set_t   set,
  input  wire dcache_pkg::tag_t   tag,
  output logic                    hit,
  output dcache_pkg::way_t        hit_way,
  output dcache_pkg::way_t        victim_way,
  output logic                    victim_dirty,
  output dcache_pkg::tag_t        victim_tag,
  input  wire                     touch,
  input  wire                     touch_dirty,
  input  wire dcache_pkg::way_t   touch_way,
  input  wire                     fill,
  input  wire dcache_pkg::way_t   fill_way
);
  import dcache_pkg::*;

  tag_t                tag_mem [NUM_WAYS][NUM_SETS];
  logic [NUM_SETS-1:0] valid   [NUM_WAYS];
  logic [NUM_SETS-1:0] dirty   [NUM_WAYS];
  age_t                age     [NUM_WAYS][NUM_SETS];

  logic [NUM_WAYS-1:0] match;
  logic [NUM_WAYS-1:0] free;

  ////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////

  always_comb
  begin
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      match[w] = valid[w][set] && (tag_mem[w][set] == tag);
      free[w]  = !valid[w][set];
    end
    for (int w = NUM_WAYS - 1; w >= 0; w--)
    begin
      if (match[w])
        hit_way = way_t'(w);
    end
  end

  assign hit = |match;

  // Lowest free way, else oldest with lowest index on ties
  always_comb
  begin
    victim_way = '0;
    if (|free)
    begin
      for (int w = NUM_WAYS - 1; w >= 0; w--)
      begin
        if (free[w])
          victim_way = way_t'(w);
      end
    end
    else
    begin
      for (int w = 1; w < NUM_WAYS; w++)
      begin
        if (age[w][set] > age[victim_way][set])
          victim_way = way_t'(w);
      end
    end
  end

  assign victim_dirty = valid[victim_way][set] && dirty[victim_way][set];
  assign victim_tag   = tag_mem[victim_way][set];

  ////////////////////////////////////////
  // Update
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int w = 0; w < NUM_WAYS; w++)
      begin
        valid[w] <= '0;
        dirty[w] <= '0;
        for (int s = 0; s < NUM_SETS; s++)
          age[w][s] <= '0;
      end
    end
    else
    begin
      if (touch)
      begin
        // Ages up to the touched one move back a step
        for (int w = 0; w < NUM_WAYS; w++)
        begin
          if (age[w][set] <= age[touch_way][set] && age[w][set] != '1)
            age[w][set] <= age[w][set] + 1'b1;
        end
        age[touch_way][set] <= '0;
        if (touch_dirty)
          dirty[touch_way][set] <= 1'b1;
      end
      if (fill)
      begin
        valid[fill_way][set] <= 1'b1;
        dirty[fill_way][set] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (fill)
      tag_mem[fill_way][set] <= tag;
  end

  a_single_match: assert property (@(posedge clk) disable iff (rst) $onehot0(match));

endmodule

`default_nettype wire

/* design/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

  ////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////

  localparam int TAG_W          = 22;
  localparam int SET_W          = 4;
  localparam int NUM_SETS       = 16;
  localparam int WORD_IDX_W     = 4;
  localparam int WORDS_PER_LINE = 16;
  localparam int OFFSET_W       = 6;   // Byte offset within a line
  localparam int NUM_WAYS       = 4;

  ////////////////////////////////////////
  // Field types
  ////////////////////////////////////////

  typedef logic [31:0]                   addr_t;
  typedef logic [31:0]                   word_t;
  typedef logic [TAG_W-1:0]              tag_t;       // addr[31:10]
  typedef logic [SET_W-1:0]              set_t;       // addr[9:6]
  typedef logic [WORD_IDX_W-1:0]         word_idx_t;  // addr[5:2]
  typedef logic [$clog2(NUM_WAYS)-1:0]   way_t;
  typedef logic [$clog2(NUM_WAYS)-1:0]   age_t;
  typedef logic [3:0]                    byte_en_t;

  // Controller FSM
  typedef enum logic [2:0]
  {
    IDLE,
    LOOKUP,
    WRITEBACK,
    REFILL,
    RESPOND
  } ctrl_state_t;

endpackage

`default_nettype wire
